//--- load_store_unit.f
design/lsu_bus_pkg.sv
design/lsu_op_pkg.sv
design/lsu_bus_fsm.sv
design/lsu_store_align.sv
design/lsu_load_align.sv
design/load_store_unit.sv
dv/lsu_tb.sv

//--- dv/lsu_tb.sv
/*
 * testbench for the load/store unit
 * clock and reset, bus model with a 64 word memory, load reference model,
 * store/load stimulus and response comparison
 */
module lsu_tb;

  localparam logic [31:0] BaseAddr = 32'h8000_0000;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  lsu_req_i;
  logic                  lsu_we_i;
  lsu_op_pkg::mem_size_e lsu_type_i;
  logic                  lsu_sign_ext_i;
  logic [31:0]           lsu_wdata_i;
  logic [31:0]           adder_result_ex_i;
  logic [31:0]           lsu_rdata_o;
  logic                  lsu_rdata_valid_o;
  logic                  lsu_resp_valid_o;
  logic                  lsu_req_done_o;
  logic                  load_err_o;
  logic                  store_err_o;
  logic                  busy_o;
  logic [31:0]           addr_last_o;
  logic                  data_req_o;
  logic [31:0]           data_addr_o;
  logic                  data_we_o;
  logic [3:0]            data_be_o;
  logic [31:0]           data_wdata_o;
  logic                  data_gnt_i;
  logic                  data_rvalid_i;
  logic                  data_err_i;
  logic [31:0]           data_rdata_i;

  // bus model memory indexed by word address
  logic [31:0] mem [64];

  // expectations queued at grant and consumed at the response
  logic        exp_we_q   [$];
  logic        exp_err_q  [$];
  logic [31:0] exp_addr_q [$];
  logic [31:0] exp_data_q [$];
  int          issued;
  int          resp_count;

  load_store_unit #(.AddrWidth(32)) dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // error reporting and reference model
  //////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    $display("Testbench failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      abort_run("value check failed");
    end
  endtask

  // RISC-V load semantics on one memory word
  function automatic logic [31:0] exp_load(input logic [31:0] word, input logic [1:0] off,
                                           input lsu_op_pkg::mem_size_e size, input logic sext);
    logic [31:0] sh;
    sh = word >> (8 * off);
    case (size)
      lsu_op_pkg::SIZE_WORD: return word;
      lsu_op_pkg::SIZE_HALF: return {{16{sext & sh[15]}}, sh[15:0]};
      default:               return {{24{sext & sh[7]}}, sh[7:0]};
    endcase
  endfunction

  function automatic int size_bytes(input lsu_op_pkg::mem_size_e size);
    if (size == lsu_op_pkg::SIZE_WORD) return 4;
    if (size == lsu_op_pkg::SIZE_HALF) return 2;
    return 1;
  endfunction

  // encoding 3 is allowed and behaves as a byte
  task automatic pick_access(output lsu_op_pkg::mem_size_e size, output logic [1:0] off);
    size = lsu_op_pkg::mem_size_e'(2'($urandom_range(3, 0)));
    case (size)
      lsu_op_pkg::SIZE_WORD: off = 2'd0;
      lsu_op_pkg::SIZE_HALF: off = 2'($urandom_range(2, 0));
      default:               off = 2'($urandom_range(3, 0));
    endcase
  endtask

  task automatic check_idle_outputs();
    check_value("data_req_o", data_req_o, 0);
    check_value("busy_o", busy_o, 0);
    check_value("lsu_req_done_o", lsu_req_done_o, 0);
    check_value("addr_last_o", addr_last_o, 0);
  endtask

  //////////////////////////////////////////////////
  // one access with grant and response from the bus model
  //////////////////////////////////////////////////

  task automatic run_access(input logic we, input int idx, input logic [31:0] wdata,
                            input logic sext);
    lsu_op_pkg::mem_size_e size;
    logic [1:0]            off;
    logic [31:0]           addr;
    logic [3:0]            be_exp;
    logic                  err;
    logic                  granted;
    int                    nbytes;
    int                    gnt_wait;
    int                    rsp_wait;
    int                    guard;
    pick_access(size, off);
    addr     = BaseAddr | (idx << 2) | off;
    nbytes   = size_bytes(size);
    be_exp   = 4'(((1 << nbytes) - 1) << off);
    gnt_wait = $urandom_range(3, 0);
    rsp_wait = $urandom_range(3, 1);
    err      = ($urandom_range(7, 0) == 0);
    @(negedge clk_i);
    lsu_req_i         = 1'b1;
    lsu_we_i          = we;
    lsu_type_i        = size;
    lsu_sign_ext_i    = sext;
    lsu_wdata_i       = wdata;
    adder_result_ex_i = addr;
    data_gnt_i        = (gnt_wait == 0);
    granted           = 1'b0;
    guard             = 0;
    // outputs must stay put under back-pressure until the grant
    while (!granted) begin
      @(posedge clk_i);
      check_value("data_req_o", data_req_o, 1);
      check_value("data_we_o", data_we_o, we);
      check_value("data_addr_o", data_addr_o, {addr[31:2], 2'b00});
      check_value("data_be_o", data_be_o, be_exp);
      check_value("busy_o", busy_o, guard > 0);
      check_value("lsu_req_done_o", lsu_req_done_o, data_gnt_i);
      for (int i = 0; i < nbytes && we; i++) begin
        check_value("data_wdata_o lane", data_wdata_o[8*(off+i) +: 8], wdata[8*i +: 8]);
      end
      if (lsu_req_done_o) begin
        granted = 1'b1;
        exp_we_q.push_back(we);
        exp_err_q.push_back(err);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(we ? 32'h0 : exp_load(mem[idx], off, size, sext));
        for (int b = 0; b < 4 && we && !err; b++) begin
          if (data_be_o[b]) mem[idx][8*b +: 8] = data_wdata_o[8*b +: 8];
        end
      end
      @(negedge clk_i);
      if (!granted) begin
        guard++;
        if (guard > 8) abort_run("grant never completed the request");
        gnt_wait--;
        data_gnt_i = (gnt_wait == 0);
      end
    end
    lsu_req_i  = 1'b0;
    data_gnt_i = 1'b0;
    // response phase
    for (int k = 1; k <= rsp_wait; k++) begin
      if (k == rsp_wait) begin
        data_rvalid_i = 1'b1;
        data_err_i    = err;
        data_rdata_i  = we ? $urandom() : mem[idx];
      end
      @(posedge clk_i);
      check_value("addr_last_o", addr_last_o, addr);
      check_value("data_req_o", data_req_o, 0);
      @(negedge clk_i);
    end
    data_rvalid_i = 1'b0;
    data_err_i    = 1'b0;
    issued++;
    guard = 0;
    while (resp_count != issued) begin
      guard++;
      if (guard > 8) abort_run("lsu_resp_valid_o missing for a bus response");
      @(negedge clk_i);
    end
  endtask

  // every response against the values queued at its grant
  always @(posedge clk_i) begin : compare_resp
    logic        we;
    logic        err;
    logic [31:0] addr;
    logic [31:0] data;
    if (rst_ni && lsu_resp_valid_o) begin
      if (exp_we_q.size() == 0) begin
        abort_run("response reported with no access outstanding");
      end else begin
        we   = exp_we_q.pop_front();
        err  = exp_err_q.pop_front();
        addr = exp_addr_q.pop_front();
        data = exp_data_q.pop_front();
        check_value("lsu_rdata_valid_o", lsu_rdata_valid_o, !we && !err);
        check_value("load_err_o", load_err_o, !we && err);
        check_value("store_err_o", store_err_o, we && err);
        check_value("addr_last_o", addr_last_o, addr);
        if (!we && !err) check_value("lsu_rdata_o", lsu_rdata_o, data);
        resp_count++;
      end
    end
  end

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h37e0cc4a));
    lsu_req_i         = 1'b0;
    lsu_we_i          = 1'b0;
    lsu_sign_ext_i    = 1'b0;
    lsu_type_i        = lsu_op_pkg::SIZE_WORD;
    lsu_wdata_i       = '0;
    adder_result_ex_i = BaseAddr;
    data_gnt_i        = 1'b0;
    data_rvalid_i     = 1'b0;
    data_err_i        = 1'b0;
    data_rdata_i      = '0;
    issued            = 0;
    resp_count        = 0;
    // fill depends on the full word address
    for (int i = 0; i < 64; i++) mem[i] = (BaseAddr + 4 * i) * 32'h9e37_79b1;
    rst_ni = 1'b0;
    repeat (8) begin
      @(posedge clk_i);
      check_idle_outputs();
    end
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(posedge clk_i);
    check_idle_outputs();
    // store into a word and load it back with a random size and offset
    for (int n = 0; n < 60; n++) begin
      int idx;
      idx = $urandom_range(63, 0);
      run_access(1'b1, idx, $urandom(), 1'b0);
      run_access(1'b0, idx, 32'h0, 1'($urandom_range(1, 0)));
    end
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- design/load_store_unit.sv
/*
 * load/store unit top level
 * request FSM plus store and load alignment between execute stage and data bus
 */
module load_store_unit #(
  parameter int unsigned AddrWidth = 32
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,

  // execute stage side
  input  logic                              lsu_req_i,
  input  logic                              lsu_we_i,
  input  lsu_op_pkg::mem_size_e             lsu_type_i,
  input  logic                              lsu_sign_ext_i,
  input  logic [lsu_bus_pkg::DataWidth-1:0] lsu_wdata_i,
  input  logic [AddrWidth-1:0]              adder_result_ex_i,

  output logic [lsu_bus_pkg::DataWidth-1:0] lsu_rdata_o,
  output logic                              lsu_rdata_valid_o,
  output logic                              lsu_resp_valid_o,
  output logic                              lsu_req_done_o,
  output logic                              load_err_o,
  output logic                              store_err_o,
  output logic [AddrWidth-1:0]              addr_last_o,
  output logic                              busy_o,

  // data bus side
  output logic                              data_req_o,
  output logic [AddrWidth-1:0]              data_addr_o,
  output logic                              data_we_o,
  output logic [lsu_bus_pkg::BeWidth-1:0]   data_be_o,
  output logic [lsu_bus_pkg::DataWidth-1:0] data_wdata_o,
  input  logic                              data_gnt_i,
  input  logic                              data_rvalid_i,
  input  logic                              data_err_i,
  input  logic [lsu_bus_pkg::DataWidth-1:0] data_rdata_i
);

  lsu_op_pkg::byte_offset_t data_offset;
  logic                     ctrl_update;

  // byte offset feeds both alignment blocks
  assign data_offset = adder_result_ex_i[lsu_bus_pkg::OffsetWidth-1:0];

  // bus only sees word addresses
  assign data_addr_o = {adder_result_ex_i[AddrWidth-1:lsu_bus_pkg::OffsetWidth],
                        {lsu_bus_pkg::OffsetWidth{1'b0}}};
  assign data_we_o   = lsu_we_i;

  //////////////////////////////////////////////////
  // request FSM
  //////////////////////////////////////////////////

  lsu_bus_fsm #(
    .AddrWidth (AddrWidth)
  ) u_bus_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .lsu_req_i         (lsu_req_i),
    .lsu_we_i          (lsu_we_i),
    .data_addr_i       (adder_result_ex_i),
    .data_gnt_i        (data_gnt_i),
    .data_rvalid_i     (data_rvalid_i),
    .data_err_i        (data_err_i),
    .data_req_o        (data_req_o),
    .ctrl_update_o     (ctrl_update),
    .lsu_req_done_o    (lsu_req_done_o),
    .lsu_resp_valid_o  (lsu_resp_valid_o),
    .lsu_rdata_valid_o (lsu_rdata_valid_o),
    .load_err_o        (load_err_o),
    .store_err_o       (store_err_o),
    .addr_last_o       (addr_last_o),
    .busy_o            (busy_o)
  );

  //////////////////////////////////////////////////
  // data alignment
  //////////////////////////////////////////////////

  lsu_store_align u_store_align (
    .lsu_type_i    (lsu_type_i),
    .data_offset_i (data_offset),
    .lsu_wdata_i   (lsu_wdata_i),
    .lsu_req_i     (lsu_req_i),
    .data_be_o     (data_be_o),
    .data_wdata_o  (data_wdata_o)
  );

  // control captured in the grant cycle, data extracted at rvalid
  lsu_load_align u_load_align (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ctrl_update_i  (ctrl_update),
    .lsu_type_i     (lsu_type_i),
    .lsu_sign_ext_i (lsu_sign_ext_i),
    .data_offset_i  (data_offset),
    .data_rdata_i   (data_rdata_i),
    .lsu_rdata_o    (lsu_rdata_o)
  );

endmodule

//--- design/lsu_load_align.sv
/*
 * load side control capture, lane selection and zero or sign extension
 */
module lsu_load_align (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              ctrl_update_i,
  input  lsu_op_pkg::mem_size_e             lsu_type_i,
  input  logic                              lsu_sign_ext_i,
  input  lsu_op_pkg::byte_offset_t          data_offset_i,
  input  logic [lsu_bus_pkg::DataWidth-1:0] data_rdata_i,
  output logic [lsu_bus_pkg::DataWidth-1:0] lsu_rdata_o
);

  lsu_op_pkg::byte_offset_t          offset_q;
  lsu_op_pkg::mem_size_e             type_q;
  logic                              sign_ext_q;
  logic [lsu_bus_pkg::DataWidth-1:0] rdata_shift;
  logic                              half_msb;
  logic                              byte_msb;

  //////////////////////////////////////////////////
  // captured access control
  //////////////////////////////////////////////////

  // request inputs are gone by the time the response arrives
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q   <= '0;
      type_q     <= lsu_op_pkg::SIZE_WORD;
      sign_ext_q <= 1'b0;
    end else if (ctrl_update_i) begin
      offset_q   <= data_offset_i;
      type_q     <= lsu_type_i;
      sign_ext_q <= lsu_sign_ext_i;
    end
  end

  //////////////////////////////////////////////////
  // lane select and extension
  //////////////////////////////////////////////////

  // addressed byte moves down to lane 0
  assign rdata_shift = data_rdata_i >> (offset_q * lsu_bus_pkg::ByteWidth);

  // fill bit is zero for unsigned loads
  assign half_msb = sign_ext_q & rdata_shift[lsu_bus_pkg::HalfWidth-1];
  assign byte_msb = sign_ext_q & rdata_shift[lsu_bus_pkg::ByteWidth-1];

  always_comb begin
    unique case (type_q)
      lsu_op_pkg::SIZE_WORD: begin
        // aligned word, nothing to move
        lsu_rdata_o = data_rdata_i;
      end
      lsu_op_pkg::SIZE_HALF: begin
        lsu_rdata_o = {{(lsu_bus_pkg::DataWidth-lsu_bus_pkg::HalfWidth){half_msb}},
                       rdata_shift[lsu_bus_pkg::HalfWidth-1:0]};
      end
      default: begin
        // byte, also covers encoding 3
        lsu_rdata_o = {{(lsu_bus_pkg::DataWidth-lsu_bus_pkg::ByteWidth){byte_msb}},
                       rdata_shift[lsu_bus_pkg::ByteWidth-1:0]};
      end
    endcase
  end

  // size select drives the output mux on every response
  size_q_known_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(type_q)
  ) else $error("captured access size is unknown");

endmodule

//--- design/lsu_store_align.sv
/*
 * store side byte enables and write data lane rotation
 */
module lsu_store_align (
  input  lsu_op_pkg::mem_size_e          lsu_type_i,
  input  lsu_op_pkg::byte_offset_t       data_offset_i,
  input  logic [lsu_bus_pkg::DataWidth-1:0] lsu_wdata_i,
  input  logic                           lsu_req_i,
  output logic [lsu_bus_pkg::BeWidth-1:0]   data_be_o,
  output logic [lsu_bus_pkg::DataWidth-1:0] data_wdata_o
);

  logic [lsu_bus_pkg::BeWidth-1:0]     be_mask;
  logic [2*lsu_bus_pkg::DataWidth-1:0] wdata_dbl;
  logic                                crosses_word;

  // enables for an access at offset 0
  always_comb begin
    unique case (lsu_type_i)
      lsu_op_pkg::SIZE_WORD: be_mask = '1;
      lsu_op_pkg::SIZE_HALF: be_mask = {{(lsu_bus_pkg::BeWidth-2){1'b0}}, 2'b11};
      default:               be_mask = {{(lsu_bus_pkg::BeWidth-1){1'b0}}, 1'b1};
    endcase
  end

  // slide the mask to the addressed lanes
  // no enables without a request
  assign data_be_o = lsu_req_i ? (be_mask << data_offset_i) : '0;

  // rotate left by whole bytes
  // upper half of the doubled word holds the wrapped result
  assign wdata_dbl    = {lsu_wdata_i, lsu_wdata_i} << (data_offset_i * lsu_bus_pkg::ByteWidth);
  assign data_wdata_o = wdata_dbl[2*lsu_bus_pkg::DataWidth-1:lsu_bus_pkg::DataWidth];

  //////////////////////////////////////////////////
  // word crossing check
  //////////////////////////////////////////////////

  // word needs offset 0, half word must not start in the last lane
  assign crosses_word =
      ((lsu_type_i == lsu_op_pkg::SIZE_WORD) && (data_offset_i != '0)) ||
      ((lsu_type_i == lsu_op_pkg::SIZE_HALF) && (data_offset_i == '1));

  always_comb begin
    if (lsu_req_i) begin
      no_word_cross_a: assert final (!crosses_word)
        else $error("access crosses a word boundary");
    end
  end

endmodule

//--- design/lsu_bus_fsm.sv
/*
 * bus request FSM for the load/store unit
 * store/load flag, response error classification, last address register
 */
module lsu_bus_fsm #(
  parameter int unsigned AddrWidth = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // request from the core
  input  logic                 lsu_req_i,
  input  logic                 lsu_we_i,
  input  logic [AddrWidth-1:0] data_addr_i,

  // bus strobes
  input  logic                 data_gnt_i,
  input  logic                 data_rvalid_i,
  input  logic                 data_err_i,
  output logic                 data_req_o,

  // grant cycle pulse for the load alignment block
  output logic                 ctrl_update_o,

  // status back to the core
  output logic                 lsu_req_done_o,
  output logic                 lsu_resp_valid_o,
  output logic                 lsu_rdata_valid_o,
  output logic                 load_err_o,
  output logic                 store_err_o,
  output logic [AddrWidth-1:0] addr_last_o,
  output logic                 busy_o
);

  typedef enum logic {
    IDLE,
    WAIT_GNT
  } lsu_state_e;

  lsu_state_e           state_q, state_d;
  logic                 ctrl_update;
  logic                 data_we_q;
  logic [AddrWidth-1:0] addr_last_q;
  logic                 resp_valid;

  //////////////////////////////////////////////////
  // request FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    data_req_o  = 1'b0;
    ctrl_update = 1'b0;

    unique case (state_q)
      IDLE: begin
        // request goes out in the same cycle it arrives
        if (lsu_req_i) begin
          data_req_o = 1'b1;
          if (data_gnt_i) begin
            ctrl_update = 1'b1;
          end else begin
            state_d = WAIT_GNT;
          end
        end
      end

      WAIT_GNT: begin
        // hold the request until the bus accepts it
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          ctrl_update = 1'b1;
          state_d     = IDLE;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////
  // grant cycle capture
  //////////////////////////////////////////////////

  // direction of the outstanding access, selects the error type later
  // full address kept for the trap value
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_we_q   <= 1'b0;
      addr_last_q <= '0;
    end else if (ctrl_update) begin
      data_we_q   <= lsu_we_i;
      addr_last_q <= data_addr_i;
    end
  end

  //////////////////////////////////////////////////
  // response classification
  //////////////////////////////////////////////////

  // only one access in flight, so a response always finds the FSM idle
  assign resp_valid = data_rvalid_i & (state_q == IDLE);

  assign ctrl_update_o     = ctrl_update;
  assign lsu_req_done_o    = ctrl_update;
  assign lsu_resp_valid_o  = resp_valid;
  assign lsu_rdata_valid_o = resp_valid & ~data_err_i & ~data_we_q;
  assign load_err_o        = resp_valid &  data_err_i & ~data_we_q;
  assign store_err_o       = resp_valid &  data_err_i &  data_we_q;
  assign addr_last_o       = addr_last_q;
  assign busy_o            = (state_q != IDLE);

  // address has to be valid for the whole request phase
  req_addr_known_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    data_req_o |-> !$isunknown(data_addr_i)
  ) else $error("data request with unknown address");

  state_legal_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    state_q inside {IDLE, WAIT_GNT}
  ) else $error("illegal FSM state");

endmodule

//--- design/lsu_op_pkg.sv
/*
 * access size opcode and byte offset type
 */
package lsu_op_pkg;

  // access size as delivered by the execute stage
  // encoding 3 is handled as a byte access
  typedef enum logic [1:0] {
    SIZE_WORD = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_BYTE = 2'd2
  } mem_size_e;

  // byte position inside a bus word
  typedef logic [lsu_bus_pkg::OffsetWidth-1:0] byte_offset_t;

endpackage

//--- design/lsu_bus_pkg.sv
/*
 * data bus widths and byte lane constants for the load/store unit
 */
package lsu_bus_pkg;

  // bus data word, the lane logic assumes four bytes
  parameter int unsigned DataWidth = 32;

  // one enable per byte lane
  parameter int unsigned BeWidth = 4;

  // address bits selecting a byte inside a word
  parameter int unsigned OffsetWidth = 2;

  // lane sizes used for rotation and extension
  parameter int unsigned ByteWidth = 8;
  parameter int unsigned HalfWidth = 16;

endpackage
